/* Bender.yml */
package:
  name: adc_capture

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/adc_capture_pkg.sv
      - verilog/sample_fifo.sv
      - verilog/capture_channel.sv
      - verilog/host_regs.sv
      - verilog/stream_merge.sv
      - verilog/adc_capture_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/adc_capture_tb.sv

/* filelist.f */
+incdir+verilog
verilog/adc_capture_pkg.sv
verilog/sample_fifo.sv
verilog/capture_channel.sv
verilog/host_regs.sv
verilog/stream_merge.sv
verilog/adc_capture_top.sv
verif/adc_capture_tb.sv

/* verif/adc_capture_tb.sv */
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module adc_capture_tb
   import adc_capture_pkg::*;
();

   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DELAY = 2;      // after the rising edge
   localparam int FIFO_WORDS  = 16;
   localparam int BUSY_CYCLES = 6000;   // mixed traffic phase
   localparam int MAX_CYCLES  = 20000;  // about three times the whole run

   logic        user_clk_out;
   logic        sys_rst_n;
   logic        adc_valid_i;
   adc_sample_t adc_i_i;
   adc_sample_t adc_q_i;
   logic        reg_wr_i;
   logic        reg_rd_i;
   reg_addr_t   reg_addr_i;
   reg_data_t   reg_wdata_i;
   reg_data_t   reg_rdata_o;
   logic        reg_rvalid_o;
   logic        out_valid_o;
   data_word_t  out_data_o;
   logic        out_channel_o;

   // reference model state per channel
   logic        model_en [2];
   divider_t    model_div [2];
   int          strobe_idx [2];    // strobes seen since enable
   logic        have_low [2];
   sample_t     low_half [2];
   word_count_t model_count [2];
   logic        model_ovf [2];
   logic        model_stream_en;
   data_word_t  exp_q0 [$];
   data_word_t  exp_q1 [$];

   logic [31:0] lcg_state;
   reg_data_t   exp_rdata;
   logic        rd_issued;
   int          cycle_cnt;
   data_word_t  exp_word;

   adc_capture_top uut (.*);

   initial begin
      user_clk_out = 1'b0;
      forever #(CLK_PERIOD/2) user_clk_out = ~user_clk_out;
   end

   ////////////////////////////////////////
   // failure reporting
   ////////////////////////////////////////
   task automatic stop_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      $display("ERR %0t ns %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      stop_run();
   endtask

   task automatic report_failure(input string reason);
      $display("%s", reason);
      stop_run();
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // model of the capture rules
   ////////////////////////////////////////
   function automatic reg_data_t status_word(input int ch);
      int level;
      level = (ch == 1) ? exp_q1.size() : exp_q0.size();
      return {28'b0, model_ovf[ch], level >= FIFO_WORDS, level == 0, model_en[ch]};
   endfunction

   function automatic reg_data_t expected_read(input reg_addr_t addr);
      reg_data_t v;
      v = '0;
      case (addr)
         `REG_CH0_CTRL:    v[0] = model_en[0];
         `REG_CH0_DIV:     v[15:0] = model_div[0];
         `REG_CH0_STATUS:  v = status_word(0);
         `REG_CH0_COUNT:   v = model_count[0];
         `REG_CH1_CTRL:    v[0] = model_en[1];
         `REG_CH1_DIV:     v[15:0] = model_div[1];
         `REG_CH1_STATUS:  v = status_word(1);
         `REG_CH1_COUNT:   v = model_count[1];
         `REG_STREAM_CTRL: v[0] = model_stream_en;
         default:          v = '0;
      endcase
      return v;
   endfunction

   task automatic model_strobe(input int ch, input adc_sample_t raw);
      sample_t    padded;
      data_word_t word;
      int         div;
      padded = {raw, 2'b00};
      div    = (model_div[ch] == 0) ? 1 : int'(model_div[ch]);
      if (model_en[ch]) begin
         if (strobe_idx[ch] % div == 0) begin
            if (!have_low[ch]) begin
               low_half[ch] = padded;
               have_low[ch] = 1'b1;
            end else begin
               have_low[ch] = 1'b0;
               word = {padded, low_half[ch]};
               // queue depth equals fifo level while the stream is off
               if ((ch == 1 ? exp_q1.size() : exp_q0.size()) >= FIFO_WORDS) begin
                  model_ovf[ch] = 1'b1;
               end else begin
                  if (ch == 1) begin
                     exp_q1.push_back(word);
                  end else begin
                     exp_q0.push_back(word);
                  end
                  model_count[ch] = model_count[ch] + 1;
               end
            end
         end
         strobe_idx[ch] = strobe_idx[ch] + 1;
      end
   endtask

   task automatic model_ctrl(input int ch, input reg_data_t data);
      model_en[ch] = data[`CTRL_ENABLE_BIT];
      if (!data[`CTRL_ENABLE_BIT]) begin
         strobe_idx[ch] = 0;       // restart decimation and pairing
         have_low[ch]   = 1'b0;
      end
      if (data[`CTRL_CLEAR_BIT]) begin
         model_count[ch] = '0;
         model_ovf[ch]   = 1'b0;
      end
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   task automatic drive_idle();
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      adc_valid_i = 1'b0;
      reg_wr_i    = 1'b0;
      reg_rd_i    = 1'b0;
   endtask

   task automatic drive_sample(input logic valid);
      logic [31:0] r;
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      r = next_random();
      adc_i_i = r[31:18];
      r = next_random();
      adc_q_i = r[31:18];
      adc_valid_i = valid;
      reg_wr_i    = 1'b0;
      reg_rd_i    = 1'b0;
      if (valid) begin
         model_strobe(0, adc_i_i);
         model_strobe(1, adc_q_i);
      end
   endtask

   task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      adc_valid_i = 1'b0;
      reg_wr_i    = 1'b1;
      reg_addr_i  = addr;
      reg_wdata_i = data;
      case (addr)
         `REG_CH0_CTRL:    model_ctrl(0, data);
         `REG_CH1_CTRL:    model_ctrl(1, data);
         `REG_CH0_DIV:     model_div[0] = data[15:0];
         `REG_CH1_DIV:     model_div[1] = data[15:0];
         `REG_STREAM_CTRL: model_stream_en = data[0];
         default: ;
      endcase
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      reg_wr_i = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr);
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      adc_valid_i = 1'b0;
      reg_rd_i    = 1'b1;
      reg_addr_i  = addr;
      exp_rdata   = expected_read(addr);
      @(posedge user_clk_out);
      #DRIVE_DELAY;
      reg_rd_i = 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
         drive_idle();
      end
   endtask

   ////////////////////////////////////////
   // checkers
   ////////////////////////////////////////
   always @(posedge user_clk_out) begin
      rd_issued = reg_rd_i;
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > MAX_CYCLES) begin
         report_failure("Timeout: the run did not finish within the cycle limit");
      end
   end

   // outputs are stable at the falling edge
   always @(negedge user_clk_out) begin
      if (sys_rst_n) begin
         assert (reg_rvalid_o == rd_issued)
            else report_value("reg_rvalid_o", 32'(rd_issued), 32'(reg_rvalid_o));
         if (reg_rvalid_o) begin
            assert (reg_rdata_o == exp_rdata)
               else report_value("reg_rdata_o", exp_rdata, reg_rdata_o);
         end
         if (out_valid_o && out_channel_o) begin
            if (exp_q1.size() == 0) begin
               report_failure("Output word tagged channel 1 arrived with none expected");
            end else begin
               exp_word = exp_q1.pop_front();
               assert (out_data_o == exp_word)
                  else report_value("out_data_o (channel 1)", exp_word, out_data_o);
            end
         end else if (out_valid_o) begin
            if (exp_q0.size() == 0) begin
               report_failure("Output word tagged channel 0 arrived with none expected");
            end else begin
               exp_word = exp_q0.pop_front();
               assert (out_data_o == exp_word)
                  else report_value("out_data_o (channel 0)", exp_word, out_data_o);
            end
         end
      end
   end

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      logic [31:0] r;
      int          i;
      sys_rst_n   = 1'b0;
      adc_valid_i = 1'b0;
      adc_i_i     = '0;
      adc_q_i     = '0;
      reg_wr_i    = 1'b0;
      reg_rd_i    = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      lcg_state   = 32'd88;
      exp_rdata   = '0;
      rd_issued   = 1'b0;
      cycle_cnt   = 0;
      model_stream_en = 1'b0;
      for (i = 0; i < 2; i++) begin
         model_en[i]    = 1'b0;
         model_div[i]   = '0;
         strobe_idx[i]  = 0;
         have_low[i]    = 1'b0;
         low_half[i]    = '0;
         model_count[i] = '0;
         model_ovf[i]   = 1'b0;
      end
      repeat (8) @(posedge user_clk_out);
      #DRIVE_DELAY;
      sys_rst_n = 1'b1;

      // reset values and register read back
      for (i = 0; i < 16; i++) begin
         read_reg(reg_addr_t'(i));
      end
      write_reg(`REG_CH0_DIV, 32'd3);
      write_reg(`REG_CH1_DIV, 32'd1);
      read_reg(`REG_CH0_DIV);
      read_reg(`REG_CH1_DIV);
      write_reg(`REG_CH0_CTRL, 32'h1);
      write_reg(`REG_CH1_CTRL, 32'h1);
      write_reg(`REG_STREAM_CTRL, 32'h1);
      read_reg(`REG_CH0_CTRL);
      read_reg(`REG_CH1_CTRL);
      read_reg(`REG_STREAM_CTRL);

      // both channels busy with random gaps in the strobe
      for (i = 0; i < BUSY_CYCLES; i++) begin
         r = next_random();
         drive_sample(r[30:29] != 2'b00);
      end
      wait_drained();
      read_reg(`REG_CH0_COUNT);
      read_reg(`REG_CH1_COUNT);
      read_reg(`REG_CH0_STATUS);
      read_reg(`REG_CH1_STATUS);
      write_reg(`REG_CH0_CTRL, 32'h0);
      write_reg(`REG_CH1_CTRL, 32'h0);

      // channel 0 overflows its fifo with the stream off
      write_reg(`REG_STREAM_CTRL, 32'h0);
      write_reg(`REG_CH0_DIV, 32'd1);
      write_reg(`REG_CH0_CTRL, 32'h3);
      read_reg(`REG_CH0_COUNT);
      for (i = 0; i < 40; i++) begin
         drive_sample(1'b1);
      end
      read_reg(`REG_CH0_STATUS);
      read_reg(`REG_CH0_COUNT);
      write_reg(`REG_CH0_CTRL, 32'h0);
      write_reg(`REG_STREAM_CTRL, 32'h1);
      wait_drained();
      repeat (4) drive_idle();   // room for a stray extra word
      read_reg(`REG_CH0_STATUS);

      // clear through the control register
      write_reg(`REG_CH0_CTRL, 32'h3);
      read_reg(`REG_CH0_COUNT);
      read_reg(`REG_CH0_STATUS);
      read_reg(`REG_CH0_CTRL);
      read_reg(`REG_CH1_COUNT);
      drive_idle();

      $display("All tests passed!");
      $finish;
   end

endmodule

/* verilog/adc_capture_macros.svh */
`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////
`define ADC_WIDTH        14   // raw converter output
`define SAMPLE_WIDTH     16   // sample after zero padding
`define WORD_WIDTH       32   // two samples packed
`define REG_ADDR_WIDTH   4

// fifo depth is 2**FIFO_DEPTH_LOG2 words
`define FIFO_DEPTH_LOG2  4

////////////////////////////////////////
// register map
////////////////////////////////////////
`define REG_CH0_CTRL     4'h0
`define REG_CH0_DIV      4'h1
`define REG_CH0_STATUS   4'h2
`define REG_CH0_COUNT    4'h3
`define REG_CH1_CTRL     4'h4
`define REG_CH1_DIV      4'h5
`define REG_CH1_STATUS   4'h6
`define REG_CH1_COUNT    4'h7
`define REG_STREAM_CTRL  4'h8

// channel control bits
`define CTRL_ENABLE_BIT  0
`define CTRL_CLEAR_BIT   1    // write-only, self clearing

`endif

/* verilog/adc_capture_pkg.sv */
`include "adc_capture_macros.svh"

package adc_capture_pkg;

   // vectors with a meaning of their own
   typedef logic [`ADC_WIDTH-1:0]      adc_sample_t;
   typedef logic [`SAMPLE_WIDTH-1:0]   sample_t;
   typedef logic [`WORD_WIDTH-1:0]     data_word_t;
   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [31:0]                reg_data_t;
   typedef logic [31:0]                word_count_t;
   typedef logic [15:0]                divider_t;     // 0 behaves as 1

   // packer phase, low half is filled first
   typedef enum logic {
      PACK_LOW,
      PACK_HIGH
   } pack_state_e;

   // which channel wins when both fifos hold data
   typedef enum logic {
      TURN_CH0,
      TURN_CH1
   } merge_turn_e;

endpackage

/* verilog/adc_capture_top.sv */
`timescale 1ns/1ps

module adc_capture_top
   import adc_capture_pkg::*;
(
   input  logic        user_clk_out,
   input  logic        sys_rst_n,
   input  logic        adc_valid_i,
   input  adc_sample_t adc_i_i,
   input  adc_sample_t adc_q_i,
   input  logic        reg_wr_i,
   input  logic        reg_rd_i,
   input  reg_addr_t   reg_addr_i,
   input  reg_data_t   reg_wdata_i,
   output reg_data_t   reg_rdata_o,
   output logic        reg_rvalid_o,
   output logic        out_valid_o,
   output data_word_t  out_data_o,
   output logic        out_channel_o
);

   logic        ch0_enable, ch1_enable;
   divider_t    ch0_divider, ch1_divider;
   logic        ch0_count_clear, ch1_count_clear;
   logic        ch0_push, ch1_push;
   data_word_t  ch0_push_data, ch1_push_data;
   word_count_t ch0_word_count, ch1_word_count;
   logic        ch0_overflow, ch1_overflow;
   logic        ch0_pop, ch1_pop;
   data_word_t  ch0_head, ch1_head;
   logic        ch0_empty, ch1_empty;
   logic        ch0_full, ch1_full;
   logic        stream_enable;

   ////////////////////////////////////////
   // capture channels, i then q
   ////////////////////////////////////////
   capture_channel u_ch0 (
      .user_clk_out, .sys_rst_n,
      .enable_i      (ch0_enable),     .divider_i   (ch0_divider),
      .count_clear_i (ch0_count_clear), .adc_valid_i (adc_valid_i),
      .adc_sample_i  (adc_i_i),        .fifo_full_i (ch0_full),
      .push_o        (ch0_push),       .push_data_o (ch0_push_data),
      .word_count_o  (ch0_word_count), .overflow_o  (ch0_overflow)
   );

   capture_channel u_ch1 (
      .user_clk_out, .sys_rst_n,
      .enable_i      (ch1_enable),     .divider_i   (ch1_divider),
      .count_clear_i (ch1_count_clear), .adc_valid_i (adc_valid_i),
      .adc_sample_i  (adc_q_i),        .fifo_full_i (ch1_full),
      .push_o        (ch1_push),       .push_data_o (ch1_push_data),
      .word_count_o  (ch1_word_count), .overflow_o  (ch1_overflow)
   );

   sample_fifo u_fifo0 (
      .user_clk_out, .sys_rst_n,
      .push_i (ch0_push), .push_data_i (ch0_push_data), .pop_i (ch0_pop),
      .head_o (ch0_head), .empty_o (ch0_empty), .full_o (ch0_full)
   );

   sample_fifo u_fifo1 (
      .user_clk_out, .sys_rst_n,
      .push_i (ch1_push), .push_data_i (ch1_push_data), .pop_i (ch1_pop),
      .head_o (ch1_head), .empty_o (ch1_empty), .full_o (ch1_full)
   );

   ////////////////////////////////////////
   // host side and output
   ////////////////////////////////////////
   host_regs u_regs (
      .user_clk_out, .sys_rst_n,
      .reg_wr_i, .reg_rd_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o, .reg_rvalid_o,
      .ch0_enable_o      (ch0_enable),      .ch1_enable_o      (ch1_enable),
      .ch0_divider_o     (ch0_divider),     .ch1_divider_o     (ch1_divider),
      .ch0_count_clear_o (ch0_count_clear), .ch1_count_clear_o (ch1_count_clear),
      .ch0_word_count_i  (ch0_word_count),  .ch1_word_count_i  (ch1_word_count),
      .ch0_overflow_i    (ch0_overflow),    .ch1_overflow_i    (ch1_overflow),
      .ch0_empty_i       (ch0_empty),       .ch1_empty_i       (ch1_empty),
      .ch0_full_i        (ch0_full),        .ch1_full_i        (ch1_full),
      .stream_enable_o   (stream_enable)
   );

   stream_merge u_merge (
      .user_clk_out, .sys_rst_n,
      .stream_enable_i (stream_enable),
      .ch0_head_i  (ch0_head),  .ch1_head_i  (ch1_head),
      .ch0_empty_i (ch0_empty), .ch1_empty_i (ch1_empty),
      .ch0_pop_o   (ch0_pop),   .ch1_pop_o   (ch1_pop),
      .out_valid_o, .out_data_o, .out_channel_o
   );

endmodule

/* verilog/capture_channel.sv */
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module capture_channel
   import adc_capture_pkg::*;
(
   input  logic        user_clk_out,
   input  logic        sys_rst_n,
   input  logic        enable_i,
   input  divider_t    divider_i,
   input  logic        count_clear_i,
   input  logic        adc_valid_i,
   input  adc_sample_t adc_sample_i,
   input  logic        fifo_full_i,
   output logic        push_o,
   output data_word_t  push_data_o,
   output word_count_t word_count_o,
   output logic        overflow_o
);

   divider_t    dec_cnt_q;
   divider_t    eff_div;
   pack_state_e phase_q;
   sample_t     padded;
   sample_t     low_q;      // first sample of the pair
   logic        keep;
   logic        word_done;

   ////////////////////////////////////////
   // decimation
   ////////////////////////////////////////
   assign eff_div = (divider_i == '0) ? divider_t'(1) : divider_i;
   assign keep    = enable_i & adc_valid_i & (dec_cnt_q == '0);

   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         dec_cnt_q <= '0;
      end else if (!enable_i) begin
         dec_cnt_q <= '0;            // next strobe after enable is kept
      end else if (adc_valid_i) begin
         if (dec_cnt_q == '0) begin
            dec_cnt_q <= eff_div - 1'b1;
         end else begin
            dec_cnt_q <= dec_cnt_q - 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // packing
   ////////////////////////////////////////
   // two zero lsbs below the converter bits
   assign padded = {adc_sample_i, {(`SAMPLE_WIDTH-`ADC_WIDTH){1'b0}}};

   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         phase_q <= PACK_LOW;
      end else if (!enable_i) begin
         phase_q <= PACK_LOW;
      end else if (keep) begin
         phase_q <= (phase_q == PACK_LOW) ? PACK_HIGH : PACK_LOW;
      end
   end

   always_ff @(posedge user_clk_out) begin
      if (keep && phase_q == PACK_LOW) begin
         low_q <= padded;
      end
   end

   assign word_done   = keep & (phase_q == PACK_HIGH);
   assign push_o      = word_done & ~fifo_full_i;   // word lost when full
   assign push_data_o = {padded, low_q};

   ////////////////////////////////////////
   // word counter and overflow flag
   ////////////////////////////////////////
   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         word_count_o <= '0;
         overflow_o   <= 1'b0;
      end else if (count_clear_i) begin
         word_count_o <= '0;
         overflow_o   <= 1'b0;
      end else begin
         if (push_o) begin
            word_count_o <= word_count_o + 1'b1;
         end
         if (word_done && fifo_full_i) begin
            overflow_o <= 1'b1;     // sticky until cleared
         end
      end
   end

endmodule

/* verilog/host_regs.sv */
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module host_regs
   import adc_capture_pkg::*;
(
   input  logic        user_clk_out,
   input  logic        sys_rst_n,
   input  logic        reg_wr_i,
   input  logic        reg_rd_i,
   input  reg_addr_t   reg_addr_i,
   input  reg_data_t   reg_wdata_i,
   output reg_data_t   reg_rdata_o,
   output logic        reg_rvalid_o,
   // channel controls
   output logic        ch0_enable_o,
   output logic        ch1_enable_o,
   output divider_t    ch0_divider_o,
   output divider_t    ch1_divider_o,
   output logic        ch0_count_clear_o,
   output logic        ch1_count_clear_o,
   // channel status
   input  word_count_t ch0_word_count_i,
   input  word_count_t ch1_word_count_i,
   input  logic        ch0_overflow_i,
   input  logic        ch1_overflow_i,
   input  logic        ch0_empty_i,
   input  logic        ch1_empty_i,
   input  logic        ch0_full_i,
   input  logic        ch1_full_i,
   output logic        stream_enable_o
);

   reg_data_t ch0_status;
   reg_data_t ch1_status;
   reg_data_t read_mux;

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////
   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         ch0_enable_o    <= 1'b0;
         ch1_enable_o    <= 1'b0;
         ch0_divider_o   <= '0;
         ch1_divider_o   <= '0;
         stream_enable_o <= 1'b0;
      end else if (reg_wr_i) begin
         case (reg_addr_i)
            `REG_CH0_CTRL:    ch0_enable_o    <= reg_wdata_i[`CTRL_ENABLE_BIT];
            `REG_CH0_DIV:     ch0_divider_o   <= divider_t'(reg_wdata_i);
            `REG_CH1_CTRL:    ch1_enable_o    <= reg_wdata_i[`CTRL_ENABLE_BIT];
            `REG_CH1_DIV:     ch1_divider_o   <= divider_t'(reg_wdata_i);
            `REG_STREAM_CTRL: stream_enable_o <= reg_wdata_i[0];
            default: ;  // status, count and holes are read only
         endcase
      end
   end

   // clear lands at the same edge as the write
   assign ch0_count_clear_o = reg_wr_i & (reg_addr_i == `REG_CH0_CTRL)
                              & reg_wdata_i[`CTRL_CLEAR_BIT];
   assign ch1_count_clear_o = reg_wr_i & (reg_addr_i == `REG_CH1_CTRL)
                              & reg_wdata_i[`CTRL_CLEAR_BIT];

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////
   // overflow, full, empty, enable from msb down
   assign ch0_status = {28'b0, ch0_overflow_i, ch0_full_i, ch0_empty_i, ch0_enable_o};
   assign ch1_status = {28'b0, ch1_overflow_i, ch1_full_i, ch1_empty_i, ch1_enable_o};

   always_comb begin
      case (reg_addr_i)
         `REG_CH0_CTRL:    read_mux = {31'b0, ch0_enable_o};
         `REG_CH0_DIV:     read_mux = {16'b0, ch0_divider_o};
         `REG_CH0_STATUS:  read_mux = ch0_status;
         `REG_CH0_COUNT:   read_mux = ch0_word_count_i;
         `REG_CH1_CTRL:    read_mux = {31'b0, ch1_enable_o};
         `REG_CH1_DIV:     read_mux = {16'b0, ch1_divider_o};
         `REG_CH1_STATUS:  read_mux = ch1_status;
         `REG_CH1_COUNT:   read_mux = ch1_word_count_i;
         `REG_STREAM_CTRL: read_mux = {31'b0, stream_enable_o};
         default:          read_mux = '0;   // unmapped
      endcase
   end

   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         reg_rdata_o  <= '0;
         reg_rvalid_o <= 1'b0;
      end else begin
         reg_rvalid_o <= reg_rd_i;
         if (reg_rd_i) begin
            reg_rdata_o <= read_mux;    // held until next read
         end
      end
   end

endmodule

/* verilog/sample_fifo.sv */
`timescale 1ns/1ps
`include "adc_capture_macros.svh"

module sample_fifo
   import adc_capture_pkg::*;
#(
   parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
   input  logic       user_clk_out,
   input  logic       sys_rst_n,
   input  logic       push_i,
   input  data_word_t push_data_i,
   input  logic       pop_i,
   output data_word_t head_o,
   output logic       empty_o,
   output logic       full_o
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   data_word_t            mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr_q;
   logic [DEPTH_LOG2-1:0] rd_ptr_q;
   logic [DEPTH_LOG2:0]   level_q;    // one bit wider to hold DEPTH

   // writer checks full, so no guard here
   always_ff @(posedge user_clk_out) begin
      if (push_i) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at DEPTH
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // show-ahead, oldest word always visible
   assign head_o  = mem[rd_ptr_q];
   assign empty_o = (level_q == '0);
   assign full_o  = (level_q == (DEPTH_LOG2+1)'(DEPTH));

endmodule

/* verilog/stream_merge.sv */
`timescale 1ns/1ps

module stream_merge
   import adc_capture_pkg::*;
(
   input  logic       user_clk_out,
   input  logic       sys_rst_n,
   input  logic       stream_enable_i,
   input  data_word_t ch0_head_i,
   input  data_word_t ch1_head_i,
   input  logic       ch0_empty_i,
   input  logic       ch1_empty_i,
   output logic       ch0_pop_o,
   output logic       ch1_pop_o,
   output logic       out_valid_o,
   output data_word_t out_data_o,
   output logic       out_channel_o
);

   merge_turn_e turn_q;

   ////////////////////////////////////////
   // round robin pick
   ////////////////////////////////////////
   // a lone non-empty fifo wins regardless of turn
   assign ch0_pop_o = stream_enable_i & ~ch0_empty_i
                      & (ch1_empty_i | (turn_q == TURN_CH0));
   assign ch1_pop_o = stream_enable_i & ~ch1_empty_i
                      & (ch0_empty_i | (turn_q == TURN_CH1));

   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         turn_q <= TURN_CH0;
      end else if (ch0_pop_o) begin
         turn_q <= TURN_CH1;
      end else if (ch1_pop_o) begin
         turn_q <= TURN_CH0;
      end
   end

   ////////////////////////////////////////
   // output register
   ////////////////////////////////////////
   always_ff @(posedge user_clk_out or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= ch0_pop_o | ch1_pop_o;
      end
   end

   always_ff @(posedge user_clk_out) begin
      if (ch0_pop_o || ch1_pop_o) begin
         out_data_o    <= ch1_pop_o ? ch1_head_i : ch0_head_i;
         out_channel_o <= ch1_pop_o;    // channel tag
      end
   end

endmodule
